// File: dv/lsu_trace.txt
# issue op a imm12 b tag | expect L/S tag result cause | commit | flush | drain | busy
# op: 0 LB 1 LBU 2 LH 3 LHU 4 LW 5 SB 6 SH 7 SW, all numbers hex
issue 7 00000040 000 8899aabb 1
expect S 1 00000000 0
commit
issue 6 00000050 002 0000f00d 2
expect S 2 00000000 0
commit
issue 5 00000060 fff 00000080 3
expect S 3 00000000 0
commit
drain
issue 4 00000040 000 00000000 4
issue 0 00000040 001 00000000 5
issue 1 00000040 001 00000000 6
issue 2 00000050 002 00000000 7
issue 3 00000050 002 00000000 0
issue 0 0000005f 000 00000000 1
expect L 4 8899aabb 0
expect L 5 ffffffaa 0
expect L 6 000000aa 0
expect L 7 fffff00d 0
expect L 0 0000f00d 0
expect L 1 ffffff80 0
issue 2 00000040 001 00000000 2
issue 4 00000042 000 00000000 3
issue 6 00000040 003 00001234 4
issue 7 00000040 002 deadbeef 5
expect L 2 00000041 1
expect L 3 00000042 1
expect S 4 00000043 2
expect S 5 00000042 2
drain
issue 4 00000040 000 00000000 6
expect L 6 8899aabb 0
issue 7 00000040 000 55555555 7
expect S 7 00000000 0
busy
issue 5 00000050 002 00000011 0
expect S 0 00000000 0
flush
drain
issue 4 00000040 000 00000000 1
issue 3 00000050 002 00000000 2
expect L 1 8899aabb 0
expect L 2 0000f00d 0
issue 7 00000080 000 cafef00d 3
expect S 3 00000000 0
commit
issue 4 00000080 000 00000000 4
expect L 4 cafef00d 0
issue 7 00000100 000 000000a1 1
issue 7 00000104 000 000000a2 2
issue 7 00000108 000 000000a3 3
issue 7 0000010c 000 000000a4 4
issue 7 00000110 000 000000a5 5
issue 7 00000114 000 000000a6 6
commit
commit
commit
commit
commit
commit
expect S 1 00000000 0
expect S 2 00000000 0
expect S 3 00000000 0
expect S 4 00000000 0
expect S 5 00000000 0
expect S 6 00000000 0
drain
issue 4 00000114 000 00000000 7
expect L 7 000000a6 0

// File: list.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_issue_queue.sv
hw/load_unit.sv
hw/store_unit.sv
hw/data_ram.sv
hw/lsu_top.sv
dv/lsu_sva.sv
dv/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim | tee sim.log \
  && grep -q '^\*\* PASS \*\*$' sim.log \
  || { echo "simulation failed"; exit 1; }

// File: dv/lsu_tb.sv
// Load/store unit testbench
`timescale 1ns/1ns

module lsu_tb;
  import lsu_pkg::*;

  localparam int wait_limit = 200;

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  lsu_issue_t issue_i;
  logic       issue_valid_i;
  logic       issue_ready_o;
  lsu_resp_t  load_resp_o;
  logic       load_valid_o;
  lsu_resp_t  store_resp_o;
  logic       store_valid_o;
  logic       commit_i;
  logic       commit_ready_o;
  logic       no_st_pending_o;

  logic [31:0] lfsr_q;
  lsu_resp_t   ld_got   [8];
  logic        ld_seen  [8];
  lsu_resp_t   st_got   [8];
  logic        st_seen  [8];

  lsu_top i_dut (.*);

  always #2 clk_i = ~clk_i;

  // ------------------------------
  // Failure and compare helpers
  // ------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input lsu_resp_t exp, input lsu_resp_t act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_cause(input string name, input ex_cause_e exp, input ex_cause_e act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch %s: expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Responses sampled at the clock edge and collected by tag
  always @(posedge clk_i) begin
    if (rst_ni && load_valid_o) begin
      if (ld_seen[load_resp_o.trans_id]) begin
        stop_run($sformatf("load tag %0d answered twice", load_resp_o.trans_id));
      end
      ld_seen[load_resp_o.trans_id] = 1'b1;
      ld_got[load_resp_o.trans_id]  = load_resp_o;
    end
    if (rst_ni && store_valid_o) begin
      if (st_seen[store_resp_o.trans_id]) begin
        stop_run($sformatf("store tag %0d answered twice", store_resp_o.trans_id));
      end
      st_seen[store_resp_o.trans_id] = 1'b1;
      st_got[store_resp_o.trans_id]  = store_resp_o;
    end
  end

  task automatic send_issue(input lsu_issue_t op_in);
    logic accepted;
    int   n;
    int   gap;
    accepted      = 1'b0;
    n             = 0;
    issue_i       = op_in;
    issue_valid_i = 1'b1;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = issue_ready_o;
      #1;
      n++;
      if (!accepted && n > wait_limit) begin
        stop_run("issue was never accepted by the DUT");
      end
    end
    issue_valid_i = 1'b0;
    // Two random bits give 0 to 3 idle cycles
    lfsr_q = lfsr_step(lfsr_q);
    gap    = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    gap    = gap + 2 * lfsr_q[0];
    repeat (gap) next_cycle();
  endtask

  task automatic send_commit();
    logic done;
    int   n;
    done     = 1'b0;
    n        = 0;
    commit_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      done = commit_ready_o;
      #1;
      n++;
      if (!done && n > wait_limit) begin
        stop_run("commit handshake never completed");
      end
    end
    commit_i = 1'b0;
  endtask

  task automatic wait_resp(input string name, input logic is_load, input trans_id_t tag,
                           input lsu_resp_t exp);
    int n;
    n = 0;
    while (!(is_load ? ld_seen[tag] : st_seen[tag])) begin
      next_cycle();
      n++;
      if (n > wait_limit) begin
        stop_run($sformatf("%s: no response for tag %0d", name, tag));
      end
    end
    if (is_load) begin
      check_cause(name, exp.cause, ld_got[tag].cause);
      check_resp(name, exp, ld_got[tag]);
      ld_seen[tag] = 1'b0;
    end else begin
      check_cause(name, exp.cause, st_got[tag].cause);
      check_resp(name, exp, st_got[tag]);
      st_seen[tag] = 1'b0;
    end
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (!no_st_pending_o) begin
      next_cycle();
      n++;
      if (n > wait_limit) begin
        stop_run($sformatf("%s: store buffer never drained", name));
      end
    end
  endtask

  // ------------------------------
  // Trace player
  // ------------------------------
  initial begin
    int          fd;
    int          lineno;
    string       line;
    string       kind;
    string       unit;
    logic [3:0]  op;
    logic [31:0] opa;
    logic [11:0] imm12;
    logic [31:0] opb;
    logic [31:0] res;
    logic [1:0]  cause;
    logic [2:0]  tag;
    lsu_issue_t  iss;
    lsu_resp_t   exp;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_i       = '0;
    issue_valid_i = 1'b0;
    commit_i      = 1'b0;
    lfsr_q        = 32'h98bb_b820;
    lineno        = 0;
    for (int i = 0; i < 8; i++) begin
      ld_seen[i] = 1'b0;
      st_seen[i] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    check_flag("reset issue_ready", 1'b1, issue_ready_o);
    check_flag("reset load_valid", 1'b0, load_valid_o);
    check_flag("reset store_valid", 1'b0, store_valid_o);
    check_flag("reset commit_ready", 1'b0, commit_ready_o);
    check_flag("reset no_st_pending", 1'b1, no_st_pending_o);

    fd = $fopen("dv/lsu_trace.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open trace file dv/lsu_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      lineno++;
      if (line.len() == 0 || line.substr(0, 0) == "#") continue;
      if ($sscanf(line, "%s", kind) != 1) continue;
      if (kind == "issue") begin
        void'($sscanf(line, "%s %h %h %h %h %h", kind, op, opa, imm12, opb, tag));
        iss.op        = lsu_op_e'(op);
        iss.operand_a = opa;
        iss.imm       = xlen_t'($signed(imm12));
        iss.operand_b = opb;
        iss.trans_id  = tag;
        send_issue(iss);
      end else if (kind == "commit") begin
        send_commit();
      end else if (kind == "flush") begin
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        next_cycle();
        // No speculative store is left to commit
        check_flag($sformatf("line %0d commit_ready", lineno), 1'b0, commit_ready_o);
      end else if (kind == "expect") begin
        void'($sscanf(line, "%s %s %h %h %h", kind, unit, tag, res, cause));
        exp = '{trans_id: tag, result: res, cause: ex_cause_e'(cause)};
        wait_resp($sformatf("line %0d", lineno), unit == "L", tag, exp);
      end else if (kind == "drain") begin
        wait_drain($sformatf("line %0d", lineno));
      end else if (kind == "busy") begin
        check_flag($sformatf("line %0d no_st_pending", lineno), 1'b0, no_st_pending_o);
      end else begin
        stop_run($sformatf("unknown trace command on line %0d", lineno));
      end
    end
    $fclose(fd);
    repeat (5) next_cycle();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: dv/lsu_sva.sv
// Load/store unit assertions
`timescale 1ns/1ns

module lsu_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                flush_i,
  input lsu_pkg::lsu_issue_t issue_i,
  input logic                issue_valid_i,
  input logic                issue_ready_o,
  input logic                load_valid_o,
  input logic                store_valid_o,
  input logic                commit_ready_o
);
  import lsu_pkg::*;

  // Issue request holds until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i && !issue_ready_o |=> issue_valid_i && $stable(issue_i))
    else $error("issue request changed before acceptance");

  // Flush empties the queue and drops in-flight responses
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> issue_ready_o && !load_valid_o && !store_valid_o)
    else $error("queue entry or response survived a flush");

  // Flush removes every speculative store
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !commit_ready_o)
    else $error("speculative store survived a flush");

endmodule

bind lsu_top lsu_sva i_sva (.*);

// File: hw/lsu_top.sv
// Load/store unit top level
`timescale 1ns/1ns

module lsu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  lsu_pkg::lsu_issue_t issue_i,
  input  logic                issue_valid_i,
  output logic                issue_ready_o,
  output lsu_pkg::lsu_resp_t  load_resp_o,
  output logic                load_valid_o,
  output lsu_pkg::lsu_resp_t  store_resp_o,
  output logic                store_valid_o,
  input  logic                commit_i,
  output logic                commit_ready_o,
  output logic                no_st_pending_o
);
  import lsu_pkg::*;

  lsu_req_t   agu_req;
  lsu_req_t   iq_head;
  logic       iq_head_valid;
  logic       pop_ld;
  logic       pop_st;
  word_addr_t ld_word;
  logic       word_match;
  mem_req_t   ld_mem;
  mem_req_t   st_mem;
  xlen_t      ram_rdata;

  lsu_agu i_agu (
    .issue_i (issue_i),
    .req_o   (agu_req)
  );

  lsu_issue_queue i_issue_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .req_i        (agu_req),
    .req_valid_i  (issue_valid_i),
    .req_ready_o  (issue_ready_o),
    .head_o       (iq_head),
    .head_valid_o (iq_head_valid),
    .pop_ld_i     (pop_ld),
    .pop_st_i     (pop_st)
  );

  load_unit i_load_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .head_i       (iq_head),
    .head_valid_i (iq_head_valid),
    .word_match_i (word_match),
    .rdata_i      (ram_rdata),
    .pop_ld_o     (pop_ld),
    .ld_word_o    (ld_word),
    .mem_o        (ld_mem),
    .resp_o       (load_resp_o),
    .valid_o      (load_valid_o)
  );

  // Store drain yields whenever the load unit uses the port
  store_unit i_store_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .head_i          (iq_head),
    .head_valid_i    (iq_head_valid),
    .commit_i        (commit_i),
    .ld_word_i       (ld_word),
    .port_busy_i     (ld_mem.req),
    .pop_st_o        (pop_st),
    .commit_ready_o  (commit_ready_o),
    .word_match_o    (word_match),
    .no_st_pending_o (no_st_pending_o),
    .mem_o           (st_mem),
    .resp_o          (store_resp_o),
    .valid_o         (store_valid_o)
  );

  data_ram i_data_ram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ld_req_i (ld_mem),
    .st_req_i (st_mem),
    .rdata_o  (ram_rdata)
  );

endmodule

// File: hw/data_ram.sv
// Single-port data RAM
`timescale 1ns/1ns
`include "lsu_defines.svh"

module data_ram (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::mem_req_t ld_req_i,
  input  lsu_pkg::mem_req_t st_req_i,
  output lsu_pkg::xlen_t    rdata_o
);
  import lsu_pkg::*;

  xlen_t    mem_q [`LSU_RAM_WORDS];
  mem_req_t port;
  xlen_t    rdata_q;

  // Load has priority on the single port
  assign port = ld_req_i.req ? ld_req_i : st_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (port.req && port.we) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (port.be[b]) begin
          mem_q[port.addr][8*b +: 8] <= port.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (port.req && !port.we) begin
      rdata_q <= mem_q[port.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hw/store_unit.sv
// Store unit with store buffer
`timescale 1ns/1ns
`include "lsu_defines.svh"

module store_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  lsu_pkg::lsu_req_t   head_i,
  input  logic                head_valid_i,
  input  logic                commit_i,
  input  lsu_pkg::word_addr_t ld_word_i,
  input  logic                port_busy_i,
  output logic                pop_st_o,
  output logic                commit_ready_o,
  output logic                word_match_o,
  output logic                no_st_pending_o,
  output lsu_pkg::mem_req_t   mem_o,
  output lsu_pkg::lsu_resp_t  resp_o,
  output logic                valid_o
);
  import lsu_pkg::*;

  localparam int unsigned ptr_w = $clog2(`LSU_SB_DEPTH);

  // Entry state, committed entries sit between drain and commit pointers
  logic [`LSU_SB_DEPTH-1:0] valid_q;
  logic [`LSU_SB_DEPTH-1:0] committed_q;
  word_addr_t               word_q  [`LSU_SB_DEPTH];
  be_t                      be_q    [`LSU_SB_DEPTH];
  xlen_t                    wdata_q [`LSU_SB_DEPTH];
  logic [ptr_w-1:0]         spec_ptr_q;
  logic [ptr_w-1:0]         commit_ptr_q;
  logic [ptr_w-1:0]         drain_ptr_q;
  logic [`LSU_SB_DEPTH-1:0] match;
  logic                     is_store;
  logic                     take;
  logic                     push;
  logic                     do_commit;
  logic                     do_drain;
  lsu_resp_t                resp_q;
  logic                     resp_valid_q;

  assign is_store = head_valid_i && (head_i.op inside {SB, SH, SW});
  assign take     = is_store && !valid_q[spec_ptr_q] && !flush_i;
  // Misaligned stores answer but never enter the buffer
  assign push     = take && !head_i.misaligned;
  assign pop_st_o = take;

  assign commit_ready_o  = valid_q[commit_ptr_q] && !committed_q[commit_ptr_q] && !flush_i;
  assign do_commit       = commit_i && commit_ready_o;
  assign do_drain        = valid_q[drain_ptr_q] && committed_q[drain_ptr_q] && !port_busy_i;
  assign no_st_pending_o = ~|valid_q;

  // ------------------------------
  // Same-word check for loads
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
      match[i] = valid_q[i] && (word_q[i] == ld_word_i);
    end
  end
  assign word_match_o = |match;

  assign mem_o.req   = do_drain;
  assign mem_o.we    = 1'b1;
  assign mem_o.addr  = word_q[drain_ptr_q];
  assign mem_o.be    = be_q[drain_ptr_q];
  assign mem_o.wdata = wdata_q[drain_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= '0;
      committed_q  <= '0;
      spec_ptr_q   <= '0;
      commit_ptr_q <= '0;
      drain_ptr_q  <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      if (flush_i) begin
        // Only committed entries survive
        valid_q    <= valid_q & committed_q;
        spec_ptr_q <= commit_ptr_q;
      end else begin
        if (push) begin
          valid_q[spec_ptr_q] <= 1'b1;
          spec_ptr_q          <= spec_ptr_q + 1'b1;
        end
        if (do_commit) begin
          committed_q[commit_ptr_q] <= 1'b1;
          commit_ptr_q              <= commit_ptr_q + 1'b1;
        end
      end
      if (do_drain) begin
        valid_q[drain_ptr_q]     <= 1'b0;
        committed_q[drain_ptr_q] <= 1'b0;
        drain_ptr_q              <= drain_ptr_q + 1'b1;
      end
      resp_valid_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      word_q[spec_ptr_q]  <= word_addr_t'(head_i.vaddr >> 2);
      be_q[spec_ptr_q]    <= head_i.be;
      wdata_q[spec_ptr_q] <= head_i.wdata;
    end
    if (take) begin
      resp_q <= '{trans_id: head_i.trans_id,
                  result:   head_i.misaligned ? xlen_t'(head_i.vaddr) : '0,
                  cause:    head_i.misaligned ? ST_MISALIGNED : NONE};
    end
  end

  assign resp_o  = resp_q;
  assign valid_o = resp_valid_q;

endmodule

// File: hw/load_unit.sv
// Load unit
`timescale 1ns/1ns

module load_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  lsu_pkg::lsu_req_t   head_i,
  input  logic                head_valid_i,
  input  logic                word_match_i,
  input  lsu_pkg::xlen_t      rdata_i,
  output logic                pop_ld_o,
  output lsu_pkg::word_addr_t ld_word_o,
  output lsu_pkg::mem_req_t   mem_o,
  output lsu_pkg::lsu_resp_t  resp_o,
  output logic                valid_o
);
  import lsu_pkg::*;

  logic       is_load;
  logic       take_rd;
  logic       take_mis;
  // Read stage
  logic       rd_valid_q;
  lsu_op_e    rd_op_q;
  logic [1:0] rd_off_q;
  trans_id_t  rd_id_q;
  // Extend stage
  xlen_t      lane;
  xlen_t      ext;
  lsu_resp_t  resp_q;
  logic       valid_q;

  assign is_load   = head_valid_i && !(head_i.op inside {SB, SH, SW});
  assign ld_word_o = word_addr_t'(head_i.vaddr >> 2);

  // Waits on a buffered store to the same word
  assign take_rd  = is_load && !head_i.misaligned && !word_match_i && !flush_i;
  // Held back while a read is in flight so the two results never collide
  assign take_mis = is_load && head_i.misaligned && !rd_valid_q && !flush_i;
  assign pop_ld_o = take_rd | take_mis;

  assign mem_o.req   = take_rd;
  assign mem_o.we    = 1'b0;
  assign mem_o.addr  = ld_word_o;
  assign mem_o.be    = head_i.be;
  assign mem_o.wdata = '0;

  // ------------------------------
  // Lane select and extension
  // ------------------------------
  assign lane = rdata_i >> {rd_off_q, 3'b000};

  always_comb begin
    unique case (rd_op_q)
      LB:      ext = xlen_t'($signed(lane[7:0]));
      LBU:     ext = xlen_t'(lane[7:0]);
      LH:      ext = xlen_t'($signed(lane[15:0]));
      LHU:     ext = xlen_t'(lane[15:0]);
      default: ext = lane;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
      valid_q    <= 1'b0;
    end else if (flush_i) begin
      rd_valid_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      rd_valid_q <= take_rd;
      valid_q    <= rd_valid_q | take_mis;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_rd) begin
      rd_op_q  <= head_i.op;
      rd_off_q <= head_i.vaddr[1:0];
      rd_id_q  <= head_i.trans_id;
    end
    if (take_mis) begin
      resp_q <= '{trans_id: head_i.trans_id, result: xlen_t'(head_i.vaddr),
                  cause: LD_MISALIGNED};
    end else if (rd_valid_q) begin
      resp_q <= '{trans_id: rd_id_q, result: ext, cause: NONE};
    end
  end

  assign resp_o  = resp_q;
  assign valid_o = valid_q;

endmodule

// File: hw/lsu_issue_queue.sv
// Issue queue
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_issue_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output lsu_pkg::lsu_req_t head_o,
  output logic              head_valid_o,
  input  logic              pop_ld_i,
  input  logic              pop_st_i
);
  import lsu_pkg::*;

  localparam int unsigned ptr_w = $clog2(`LSU_IQ_DEPTH);
  localparam int unsigned cnt_w = $clog2(`LSU_IQ_DEPTH + 1);

  lsu_req_t         mem_q [`LSU_IQ_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push;
  logic             pop;

  assign req_ready_o  = count_q != cnt_w'(`LSU_IQ_DEPTH);
  assign head_valid_o = count_q != '0;
  assign head_o       = mem_q[rd_ptr_q];

  assign push = req_valid_i & req_ready_o;
  assign pop  = (pop_ld_i | pop_st_i) & head_valid_o;

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

// File: hw/lsu_agu.sv
// Address generation and decode
`timescale 1ns/1ns

module lsu_agu (
  input  lsu_pkg::lsu_issue_t issue_i,
  output lsu_pkg::lsu_req_t   req_o
);
  import lsu_pkg::*;

  addr_t      vaddr;
  logic [1:0] offset;
  be_t        be;
  logic       misaligned;

  // Physical address, upper sum bits fall outside the RAM
  assign vaddr  = addr_t'(issue_i.operand_a + issue_i.imm);
  assign offset = vaddr[1:0];

  // ------------------------------
  // Byte enables and alignment
  // ------------------------------
  always_comb begin
    be         = '1;
    misaligned = 1'b0;
    unique case (issue_i.op)
      LB, LBU, SB: begin
        be = be_t'(4'b0001) << offset;
      end
      LH, LHU, SH: begin
        be         = be_t'(4'b0011) << offset;
        misaligned = offset[0];
      end
      // Word accesses
      default: begin
        misaligned = |offset;
      end
    endcase
  end

  assign req_o.op         = issue_i.op;
  assign req_o.vaddr      = vaddr;
  // Store data moves into its byte lane
  assign req_o.wdata      = issue_i.operand_b << {offset, 3'b000};
  assign req_o.be         = be;
  assign req_o.trans_id   = issue_i.trans_id;
  assign req_o.misaligned = misaligned;

endmodule

// File: hw/lsu_pkg.sv
// Load/store unit types
`include "lsu_defines.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0]          xlen_t;
  typedef logic [`LSU_ADDR_BITS-1:0]     addr_t;
  typedef logic [`LSU_ADDR_BITS-3:0]     word_addr_t;
  typedef logic [`LSU_XLEN/8-1:0]        be_t;
  typedef logic [`LSU_TRANS_ID_BITS-1:0] trans_id_t;

  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  typedef enum logic [1:0] {
    NONE,
    LD_MISALIGNED,
    ST_MISALIGNED
  } ex_cause_e;

  // Operation as it arrives from issue
  typedef struct packed {
    lsu_op_e   op;
    xlen_t     operand_a;
    xlen_t     imm;
    xlen_t     operand_b;
    trans_id_t trans_id;
  } lsu_issue_t;

  // Decoded request held in the issue queue
  typedef struct packed {
    lsu_op_e   op;
    addr_t     vaddr;
    xlen_t     wdata;
    be_t       be;
    trans_id_t trans_id;
    logic      misaligned;
  } lsu_req_t;

  typedef struct packed {
    trans_id_t trans_id;
    xlen_t     result;
    ex_cause_e cause;
  } lsu_resp_t;

  // One access on the RAM port
  typedef struct packed {
    logic       req;
    logic       we;
    word_addr_t addr;
    be_t        be;
    xlen_t      wdata;
  } mem_req_t;

endpackage

// File: include/lsu_defines.svh
// Load/store unit parameters
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data path width
`define LSU_XLEN 32

// Local data RAM, 256 words of 32 bits
`define LSU_RAM_WORDS 256
`define LSU_ADDR_BITS 10

// Scoreboard tag width
`define LSU_TRANS_ID_BITS 3

// Queue and buffer depths, powers of two
`define LSU_IQ_DEPTH 2
`define LSU_SB_DEPTH 4

`endif
